// ==== filelist.f ====
+incdir+hw
+incdir+sim
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_core_fsm.sv
hw/rv_perf_counter.sv
hw/rv_core.sv
sim/rv_core_tb.sv

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_alu
    import rv_pkg::*;
(
    input  wire         [`RV_XLEN-1:0] rs1_value,
    input  wire         [`RV_XLEN-1:0] rs2_value,
    input  wire         [`RV_XLEN-1:0] imm,
    input  wire         [`RV_XLEN-1:0] pc,
    input  wire alu_op_e               alu_op,
    input  wire inst_class_e           inst_class,
    input  wire                        use_imm,
    output logic        [`RV_XLEN-1:0] result,
    output logic                       branch_taken
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;

    assign op_a = (inst_class == IC_AUIPC) ? pc : rs1_value;
    assign op_b = use_imm ? imm : rs2_value;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // zero result means equal operands for both sub and xor
    assign branch_taken = (inst_class == IC_BRANCH) &&
                          ((alu_op == ALU_SUB) ? (result == '0) : (result != '0));

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_core
    import rv_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    output logic                mem_req,
    output logic                mem_we,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    input  wire                 mem_ack,
    input  wire  [`RV_XLEN-1:0] mem_rdata,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data,
    output logic                halted,
    output logic                illegal,
    output logic [`RV_XLEN-1:0] a0_value,
    output logic [`RV_XLEN-1:0] cycle_count,
    output logic [`RV_XLEN-1:0] instret_count
);

    logic [`RV_XLEN-1:0] inst;
    logic [`RV_XLEN-1:0] pc;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] imm;
    alu_op_e             alu_op;
    inst_class_e         inst_class;
    logic                use_imm;
    logic [`RV_XLEN-1:0] rs1_value;
    logic [`RV_XLEN-1:0] rs2_value;
    logic [`RV_XLEN-1:0] alu_result;
    logic                branch_taken;
    logic                rf_wen;

    rv_decoder rv_decoder_i (
        .inst       (inst),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (retire_rd),
        .imm        (imm),
        .alu_op     (alu_op),
        .inst_class (inst_class),
        .use_imm    (use_imm)
    );

    rv_regfile rv_regfile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (retire_rd),
        .wdata     (retire_data),
        .wen       (rf_wen),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .a0_value  (a0_value)
    );

    rv_alu rv_alu_i (
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .imm          (imm),
        .pc           (pc),
        .alu_op       (alu_op),
        .inst_class   (inst_class),
        .use_imm      (use_imm),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    rv_core_fsm rv_core_fsm_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .inst_class   (inst_class),
        .imm          (imm),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .inst         (inst),
        .pc           (pc),
        .rf_wen       (rf_wen),
        .rf_wdata     (retire_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .halted       (halted),
        .illegal      (illegal)
    );

    rv_perf_counter #(
        .WIDTH (`RV_XLEN)
    ) rv_perf_counter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .retire_valid  (retire_valid),
        .halted        (halted),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

endmodule

`default_nettype wire

// ==== hw/rv_core_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_core_fsm
    import rv_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        mem_ack,
    input  wire         [`RV_XLEN-1:0] mem_rdata,
    input  wire inst_class_e           inst_class,
    input  wire         [`RV_XLEN-1:0] imm,
    input  wire         [`RV_XLEN-1:0] rs1_value,
    input  wire         [`RV_XLEN-1:0] rs2_value,
    input  wire         [`RV_XLEN-1:0] alu_result,
    input  wire                        branch_taken,
    output logic                       mem_req,
    output logic                       mem_we,
    output logic        [`RV_XLEN-1:0] mem_addr,
    output logic        [`RV_XLEN-1:0] mem_wdata,
    output logic        [`RV_XLEN-1:0] inst,
    output logic        [`RV_XLEN-1:0] pc,
    output logic                       rf_wen,
    output logic        [`RV_XLEN-1:0] rf_wdata,
    output logic                       retire_valid,
    output logic        [`RV_XLEN-1:0] retire_pc,
    output logic                       halted,
    output logic                       illegal
);

    core_state_e         state;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] snpc;
    logic [`RV_XLEN-1:0] dnpc;
    logic [`RV_XLEN-1:0] next_pc;
    logic                writes_rd;

    assign snpc = pc + 32'd4;
    // jalr clears bit 0, jal and branches are pc relative
    assign dnpc = (inst_class == IC_JALR) ? ((rs1_value + imm) & ~32'd1) : (pc + imm);
    assign next_pc = (inst_class inside {IC_JAL, IC_JALR} || branch_taken) ? dnpc : snpc;

    assign writes_rd = inst_class inside {IC_ALU_REG, IC_ALU_IMM, IC_LUI, IC_AUIPC,
                                          IC_LOAD, IC_JAL, IC_JALR};

    always_comb begin
        case (inst_class)
            IC_JAL, IC_JALR: rf_wdata = snpc;
            IC_LOAD:         rf_wdata = load_data;
            default:         rf_wdata = writes_rd ? alu_result : '0;
        endcase
    end

    assign rf_wen       = (state == ST_WB) && writes_rd;
    assign retire_valid = (state == ST_WB);
    assign retire_pc    = pc;
    assign halted       = (state == ST_HALT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_FETCH;
            pc       <= `RV_RESET_PC;
            mem_addr <= `RV_RESET_PC;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            case (state)
                ST_FETCH, ST_MEM: begin
                    if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= (state == ST_FETCH) ? ST_FETCH_REL : ST_MEM_REL;
                    end else if (!mem_ack) begin
                        mem_req <= 1'b1;
                    end
                end
                ST_FETCH_REL: if (!mem_ack) state <= ST_EXEC;
                ST_EXEC: begin
                    if (inst_class == IC_ILLEGAL) begin
                        illegal <= 1'b1;
                        state   <= ST_HALT;
                    end else if (inst_class inside {IC_LOAD, IC_STORE}) begin
                        mem_addr <= alu_result;
                        mem_we   <= (inst_class == IC_STORE);
                        state    <= ST_MEM;
                    end else begin
                        state <= ST_WB;
                    end
                end
                ST_MEM_REL: if (!mem_ack) state <= ST_WB;
                ST_WB: begin
                    pc       <= next_pc;
                    mem_addr <= next_pc;
                    mem_we   <= 1'b0;
                    state    <= (inst_class == IC_EBREAK) ? ST_HALT : ST_FETCH;
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FETCH && mem_req && mem_ack) begin
            inst <= mem_rdata;
        end
        if (state == ST_MEM && mem_req && mem_ack) begin
            load_data <= mem_rdata;
        end
        if (state == ST_EXEC) begin
            mem_wdata <= rs2_value;
        end
    end

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_ack) |=> $stable(mem_addr));

    // the release phase must finish before the next request
    no_req_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (!mem_req && mem_ack) |=> !mem_req);

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_decoder
    import rv_pkg::*;
(
    input  wire         [`RV_XLEN-1:0] inst,
    output logic        [4:0]          rs1,
    output logic        [4:0]          rs2,
    output logic        [4:0]          rd,
    output logic        [`RV_XLEN-1:0] imm,
    output alu_op_e                    alu_op,
    output inst_class_e                inst_class,
    output logic                       use_imm
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    alu_op_e             f3_op;
    logic                f3_ok;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 map shared by the register and immediate forms, shifts and sltu excluded
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            3'b000:  f3_op = ALU_ADD;
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        inst_class = IC_ILLEGAL;
        alu_op     = ALU_ADD;
        use_imm    = 1'b1;
        case (opcode)
            7'b0110111: begin
                inst_class = IC_LUI;
                alu_op     = ALU_PASS_B;
            end
            7'b0010111: inst_class = IC_AUIPC;
            7'b0010011: begin
                alu_op = f3_op;
                if (f3_ok) begin
                    inst_class = IC_ALU_IMM;
                end
            end
            7'b0110011: begin
                use_imm = 1'b0;
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    inst_class = IC_ALU_REG;
                    alu_op     = ALU_SUB;
                end else if (funct7 == 7'b0000000 && f3_ok) begin
                    inst_class = IC_ALU_REG;
                    alu_op     = f3_op;
                end
            end
            7'b0000011: if (funct3 == 3'b010) inst_class = IC_LOAD;
            7'b0100011: if (funct3 == 3'b010) inst_class = IC_STORE;
            7'b1101111: inst_class = IC_JAL;
            7'b1100111: if (funct3 == 3'b000) inst_class = IC_JALR;
            7'b1100011: begin
                // beq compares through sub, bne through xor, the alu tells them apart
                use_imm = 1'b0;
                alu_op  = funct3[0] ? ALU_XOR : ALU_SUB;
                if (funct3[2:1] == 2'b00) begin
                    inst_class = IC_BRANCH;
                end
            end
            7'b1110011: if (inst == `RV_EBREAK) inst_class = IC_EBREAK;
            default: inst_class = IC_ILLEGAL;
        endcase
    end

    always_comb begin
        case (inst_class)
            IC_ALU_IMM, IC_LOAD, IC_JALR: imm = imm_i;
            IC_STORE:                     imm = imm_s;
            IC_BRANCH:                    imm = imm_b;
            IC_LUI, IC_AUIPC:             imm = imm_u;
            IC_JAL:                       imm = imm_j;
            default:                      imm = '0;
        endcase
    end

    // rd reads as zero for classes without a destination
    assign rd = (inst_class inside {IC_ALU_REG, IC_ALU_IMM, IC_LUI, IC_AUIPC, IC_LOAD,
                                    IC_JAL, IC_JALR}) ? inst[11:7] : 5'd0;

endmodule

`default_nettype wire

// ==== hw/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// data and address width
`define RV_XLEN 32

// only system encoding the core accepts
`define RV_EBREAK 32'h0010_0073

`endif

// ==== hw/rv_perf_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_perf_counter #(
    parameter int WIDTH = 32
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              retire_valid,
    input  wire              halted,
    output logic [WIDTH-1:0] cycle_count,
    output logic [WIDTH-1:0] instret_count
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_count   <= '0;
            instret_count <= '0;
        end else if (!halted) begin
            cycle_count <= cycle_count + 1'b1;
            if (retire_valid) begin
                instret_count <= instret_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_SLT    = 3'd2,
        ALU_XOR    = 3'd3,
        ALU_OR     = 3'd4,
        ALU_AND    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    typedef enum logic [3:0] {
        IC_ALU_REG = 4'd0,
        IC_ALU_IMM = 4'd1,
        IC_LUI     = 4'd2,
        IC_AUIPC   = 4'd3,
        IC_LOAD    = 4'd4,
        IC_STORE   = 4'd5,
        IC_JAL     = 4'd6,
        IC_JALR    = 4'd7,
        IC_BRANCH  = 4'd8,
        IC_EBREAK  = 4'd9,
        IC_ILLEGAL = 4'd10
    } inst_class_e;

    // one instruction in flight, memory phases split into req and release
    typedef enum logic [2:0] {
        ST_FETCH     = 3'd0,
        ST_FETCH_REL = 3'd1,
        ST_EXEC      = 3'd2,
        ST_MEM       = 3'd3,
        ST_MEM_REL   = 3'd4,
        ST_WB        = 3'd5,
        ST_HALT      = 3'd6
    } core_state_e;

endpackage

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_regfile (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [4:0]          rs1,
    input  wire  [4:0]          rs2,
    input  wire  [4:0]          rd,
    input  wire  [`RV_XLEN-1:0] wdata,
    input  wire                 wen,
    output logic [`RV_XLEN-1:0] rs1_value,
    output logic [`RV_XLEN-1:0] rs2_value,
    output logic [`RV_XLEN-1:0] a0_value
);

    logic [`RV_XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign a0_value  = regs[10];

    // a write aimed at x0 leaves the storage cleared
    x0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (wen && rd == 5'd0) |=> (regs[0] == '0));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module rv_core_tb \
    -f filelist.f \
    -Mdir obj_dir \
    -o rv_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/rv_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== sim/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam int OPC_LUI   = 'h37;
localparam int OPC_AUIPC = 'h17;
localparam int OPC_IMM   = 'h13;
localparam int OPC_LOAD  = 'h03;
localparam int OPC_JALR  = 'h67;

logic [31:0] lcg_state = 32'h628c;
logic [31:0] exp_mem [256];
logic [31:0] exp_pc [$];
logic [4:0]  exp_rd [$];
logic [31:0] exp_data [$];
logic [31:0] exp_a0;
logic [31:0] exp_count;
logic        exp_illegal;
int          load_ptr;

// ack delay of 0 to 3 cycles from the upper lcg bits
function automatic logic [1:0] random_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[17:16];
endfunction

function automatic logic [31:0] r_type(input int rd, input int f3, input int rs1,
                                       input int rs2, input int f7);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] i_type(input int op, input int rd, input int f3,
                                       input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                       input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] u_type(input int op, input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
endfunction

function automatic void place_word(input logic [31:0] word);
    mem[load_ptr] = word;
    load_ptr++;
endfunction

function automatic void load_program(input int id);
    for (int i = 0; i < 256; i++) begin
        mem[i] = 32'hc0de_0000 ^ (32'(i) << 2);
    end
    load_ptr = 0;
    case (id)
        1: begin
            place_word(i_type(OPC_IMM, 1, 0, 0, 'h200));
            place_word(u_type(OPC_LUI, 2, 'habcde));
            place_word(i_type(OPC_IMM, 2, 0, 2, 'h123));
            place_word(s_type(2, 1, 0));
            place_word(s_type(1, 1, 4));
            place_word(i_type(OPC_LOAD, 3, 2, 1, 0));
            place_word(i_type(OPC_LOAD, 4, 2, 1, 4));
            place_word(i_type(OPC_LOAD, 5, 2, 1, 8));
            place_word(i_type(OPC_LOAD, 6, 2, 1, -4));
            place_word(r_type(10, 0, 3, 4, 0));
            place_word(`RV_EBREAK);
        end
        2: begin
            // counting loop, a skipped addi, then a call and return through jalr
            place_word(i_type(OPC_IMM, 1, 0, 0, 0));
            place_word(i_type(OPC_IMM, 2, 0, 0, 5));
            place_word(i_type(OPC_IMM, 1, 0, 1, 1));
            place_word(b_type(1, 1, 2, -4));
            place_word(b_type(0, 1, 2, 8));
            place_word(i_type(OPC_IMM, 3, 0, 0, 99));
            place_word(j_type(5, 16));
            place_word(r_type(10, 0, 10, 1, 0));
            place_word(`RV_EBREAK);
            place_word(i_type(OPC_IMM, 3, 0, 0, 77));
            place_word(i_type(OPC_IMM, 10, 0, 0, 100));
            place_word(i_type(OPC_JALR, 6, 0, 5, 1));
        end
        3: begin
            // sll is outside the kept subset
            place_word(i_type(OPC_IMM, 10, 0, 0, 7));
            place_word(r_type(5, 1, 1, 2, 0));
            place_word(i_type(OPC_IMM, 10, 0, 0, 9));
        end
        default: begin
            place_word(u_type(OPC_LUI, 1, 'h12345));
            place_word(u_type(OPC_AUIPC, 2, 'h1));
            place_word(i_type(OPC_IMM, 3, 0, 1, 'h678));
            place_word(i_type(OPC_IMM, 4, 2, 3, -1));
            place_word(i_type(OPC_IMM, 5, 4, 3, 'h0ff));
            place_word(i_type(OPC_IMM, 6, 6, 3, -256));
            place_word(i_type(OPC_IMM, 7, 7, 3, 'h7f0));
            place_word(r_type(8, 0, 1, 2, 0));
            place_word(r_type(9, 0, 1, 2, 'h20));
            place_word(r_type(11, 2, 9, 3, 0));
            place_word(r_type(12, 4, 5, 6, 0));
            place_word(r_type(13, 6, 4, 7, 0));
            place_word(r_type(14, 7, 6, 3, 0));
            place_word(i_type(OPC_IMM, 0, 0, 1, 5));
            place_word(r_type(10, 0, 0, 12, 0));
            place_word(`RV_EBREAK);
        end
    endcase
endfunction

function automatic logic [31:0] compute_alu(input logic [2:0] f3, input logic [31:0] x,
                                            input logic [31:0] y, output logic ok);
    ok = 1'b1;
    case (f3)
        3'd0:    return x + y;
        3'd2:    return {31'd0, $signed(x) < $signed(y)};
        3'd4:    return x ^ y;
        3'd6:    return x | y;
        3'd7:    return x & y;
        default: begin
            ok = 1'b0;
            return 32'd0;
        end
    endcase
endfunction

// runs the loaded program on a private copy of memory and registers
function automatic void run_reference();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] wval;
    logic [31:0] npc;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        writes;
    logic        bad;
    logic        ok;
    logic        done;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        regs[i] = 32'd0;
    end
    for (int i = 0; i < 256; i++) begin
        exp_mem[i] = mem[i];
    end
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    exp_illegal = 1'b0;
    pc = `RV_RESET_PC;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 2000) begin
        ins    = exp_mem[pc[9:2]];
        f3     = ins[14:12];
        rd     = ins[11:7];
        a      = regs[ins[19:15]];
        b      = regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        writes = 1'b1;
        bad    = 1'b0;
        ok     = 1'b1;
        wval   = 32'd0;
        npc    = pc + 32'd4;
        case (ins[6:0])
            7'h37: wval = {ins[31:12], 12'd0};
            7'h17: wval = pc + {ins[31:12], 12'd0};
            7'h13: begin
                wval = compute_alu(f3, a, imm_i, ok);
                bad  = !ok;
            end
            7'h33: begin
                if (ins[31:25] == 7'h20 && f3 == 3'd0) begin
                    wval = a - b;
                end else if (ins[31:25] == 7'h00) begin
                    wval = compute_alu(f3, a, b, ok);
                    bad  = !ok;
                end else begin
                    bad = 1'b1;
                end
            end
            7'h03: begin
                addr = a + imm_i;
                wval = exp_mem[addr[9:2]];
                bad  = (f3 != 3'd2);
            end
            7'h23: begin
                writes = 1'b0;
                addr   = a + imm_s;
                if (f3 == 3'd2) begin
                    exp_mem[addr[9:2]] = b;
                end else begin
                    bad = 1'b1;
                end
            end
            7'h6f: begin
                wval = pc + 32'd4;
                npc  = pc + imm_j;
            end
            7'h67: begin
                wval = pc + 32'd4;
                npc  = (a + imm_i) & ~32'd1;
                bad  = (f3 != 3'd0);
            end
            7'h63: begin
                writes = 1'b0;
                if (f3 == 3'd0 && a == b) begin
                    npc = pc + imm_b;
                end else if (f3 == 3'd1 && a != b) begin
                    npc = pc + imm_b;
                end
                bad = (f3 > 3'd1);
            end
            7'h73: begin
                writes = 1'b0;
                done   = (ins == `RV_EBREAK);
                bad    = (ins != `RV_EBREAK);
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            exp_illegal = 1'b1;
            done        = 1'b1;
        end else begin
            exp_pc.push_back(pc);
            exp_rd.push_back(writes ? rd : 5'd0);
            exp_data.push_back(writes ? wval : 32'd0);
            if (writes && rd != 5'd0) begin
                regs[rd] = wval;
            end
            pc = npc;
        end
        steps++;
    end
    exp_a0    = regs[10];
    exp_count = exp_pc.size();
endfunction

`endif

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_core_tb;

    localparam int NUM_TESTS = 5;
    localparam int MAX_DELAY = 3;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                mem_req;
    logic                mem_we;
    logic [`RV_XLEN-1:0] mem_addr;
    logic [`RV_XLEN-1:0] mem_wdata;
    logic                mem_ack;
    logic [`RV_XLEN-1:0] mem_rdata;
    logic                retire_valid;
    logic [`RV_XLEN-1:0] retire_pc;
    logic [4:0]          retire_rd;
    logic [`RV_XLEN-1:0] retire_data;
    logic                halted;
    logic                illegal;
    logic [`RV_XLEN-1:0] a0_value;
    logic [`RV_XLEN-1:0] cycle_count;
    logic [`RV_XLEN-1:0] instret_count;

    logic [31:0]         mem [256];
    string               test_name = "none";
    logic [31:0]         retire_seen = 32'd0;
    logic [31:0]         watchdog_cycles = 32'd0;

    `include "rv_ref_model.svh"

    rv_core rv_core_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req       (mem_req),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data),
        .halted        (halted),
        .illegal       (illegal),
        .a0_value      (a0_value),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_word(input string what, input logic [`RV_XLEN-1:0] expected,
                              input logic [`RV_XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s expected %h actual %h",
                     test_name, what, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_reg(input string what, input logic [4:0] expected,
                             input logic [4:0] actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s expected %0d actual %0d",
                     test_name, what, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s expected %b actual %b",
                     test_name, what, expected, actual);
            stop_run();
        end
    endtask

    function automatic string test_label(input int id);
        case (id)
            0:       return "alu_straight";
            1:       return "load_store";
            2:       return "branch_loop";
            3:       return "illegal_halt";
            default: return "rerun_after_reset";
        endcase
    endfunction

    // memory responder, four-phase handshake with random delays in both phases
    initial begin
        logic [1:0] ack_delay;
        mem_ack   = 1'b0;
        mem_rdata = 32'd0;
        forever begin
            @(posedge clk);
            #2;
            if (rst_n && mem_req && !mem_ack) begin
                ack_delay = random_delay();
                repeat (ack_delay) begin
                    @(posedge clk);
                    #2;
                end
                if (mem_we) begin
                    mem[mem_addr[9:2]] = mem_wdata;
                end else begin
                    mem_rdata = mem[mem_addr[9:2]];
                end
                mem_ack = 1'b1;
                while (mem_req) begin
                    @(posedge clk);
                    #2;
                end
                ack_delay = random_delay();
                repeat (ack_delay) begin
                    @(posedge clk);
                    #2;
                end
                mem_ack = 1'b0;
            end
        end
    end

    // every retire pulse against the next reference entry
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && retire_valid) begin
                if (exp_pc.size() == 0) begin
                    $display("retire pulse seen when no instruction was expected");
                    stop_run();
                end else begin
                    check_word("retire_pc", exp_pc.pop_front(), retire_pc);
                    check_reg("retire_rd", exp_rd.pop_front(), retire_rd);
                    check_word("retire_data", exp_data.pop_front(), retire_data);
                    retire_seen = retire_seen + 32'd1;
                end
            end
        end
    end

    // handshake protocol and quiet bus after halt
    initial begin
        logic req_prev;
        logic ack_prev;
        req_prev = 1'b0;
        ack_prev = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req && !req_prev && ack_prev) begin
                $display("mem_req rose while mem_ack was still high");
                stop_run();
            end else if (rst_n && halted && mem_req) begin
                $display("mem_req raised after the core halted");
                stop_run();
            end else begin
                req_prev = mem_req;
                ack_prev = mem_ack;
            end
        end
    end

    initial begin
        wait (watchdog_cycles != 32'd0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before the tests finished");
        stop_run();
    end

    task automatic run_test(input int id);
        logic [`RV_XLEN-1:0] cycles_at_halt;
        logic [`RV_XLEN-1:0] instret_at_halt;
        test_name = test_label(id);
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        load_program(id);
        run_reference();
        retire_seen = 32'd0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_flag("mem_req after reset", 1'b0, mem_req);
        check_flag("retire_valid after reset", 1'b0, retire_valid);
        check_flag("halted after reset", 1'b0, halted);
        check_flag("illegal after reset", 1'b0, illegal);
        check_word("fetch address after reset", `RV_RESET_PC, mem_addr);
        check_word("cycle_count after reset", 32'd0, cycle_count);
        check_word("instret_count after reset", 32'd0, instret_count);
        while (!halted) begin
            @(negedge clk);
        end
        check_word("retire count", exp_count, retire_seen);
        check_flag("illegal", exp_illegal, illegal);
        check_word("a0_value", exp_a0, a0_value);
        check_word("instret_count", exp_count, instret_count);
        cycles_at_halt  = cycle_count;
        instret_at_halt = instret_count;
        repeat (8) @(negedge clk);
        check_flag("halted held", 1'b1, halted);
        check_word("cycle_count frozen", cycles_at_halt, cycle_count);
        check_word("instret_count frozen", instret_at_halt, instret_count);
        for (int i = 0; i < 256; i++) begin
            check_word($sformatf("memory word %0d", i), exp_mem[i], mem[i]);
        end
    endtask

    initial begin
        logic [31:0] total;
        rst_n = 1'b0;
        total = 32'd0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            load_program(t);
            run_reference();
            total = total + exp_count;
        end
        watchdog_cycles = total * 32'd40 * MAX_DELAY + 32'd600;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
